// ==== rtl/dcache_pkg.sv ====
//////////////////////////////////////////////////
// dcache package
// cache geometry, access lengths and the request
// and write-through structs shared by the blocks
//////////////////////////////////////////////////

package dcache_pkg;

    // address and line geometry
    localparam int addr_bits  = 64;
    localparam int line_bytes = 128;
    localparam int line_bits  = line_bytes * 8;
    localparam int offs_bits  = 7;

    // 4 sets of 4 ways
    localparam int set_bits = 2;
    localparam int num_sets = 1 << set_bits;
    localparam int way_bits = 2;
    localparam int num_ways = 1 << way_bits;

    localparam int tag_bits = addr_bits - set_bits - offs_bits;

    // follows the load/store funct3 field, 7 is illegal
    typedef enum logic [2:0] {
        len_b  = 3'd0,
        len_h  = 3'd1,
        len_w  = 3'd2,
        len_d  = 3'd3,
        len_bu = 3'd4,
        len_hu = 3'd5,
        len_wu = 3'd6
    } mem_len_e;

    // decoded request, store data already placed at its line offset
    typedef struct packed {
        logic [tag_bits-1:0]   tag;
        logic [set_bits-1:0]   set;
        logic [offs_bits-1:0]  offs;
        mem_len_e              len;
        logic                  rd;
        logic                  wr;
        logic [line_bytes-1:0] mask;
        logic [line_bits-1:0]  wdata;
    } dc_req_t;

    // one write-through transfer
    typedef struct packed {
        logic [addr_bits-1:0] addr;
        logic [line_bits-1:0] line;
    } bus_wr_t;

endpackage

// ==== rtl/dcache_req_decode.sv ====
//////////////////////////////////////////////////
// dcache request decoder
// splits the address and builds the store byte
// mask and line-aligned store data
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dcache_req_decode
    import dcache_pkg::*;
(
    input  logic [addr_bits-1:0] addr,
    input  mem_len_e             len,
    input  logic                 rd,
    input  logic                 wr,
    input  logic [63:0]          data_in,
    output dc_req_t              req
);

    logic [1:0] size;
    logic [7:0] byte_mask;

    // low two bits of len give log2 of the access size
    assign size = len[1:0];

    always_comb begin
        case (size)
            2'd0:    byte_mask = 8'h01;
            2'd1:    byte_mask = 8'h03;
            2'd2:    byte_mask = 8'h0f;
            default: byte_mask = 8'hff;
        endcase
    end

    // address split
    assign req.tag  = addr[addr_bits-1 -: tag_bits];
    assign req.set  = addr[offs_bits +: set_bits];
    assign req.offs = addr[offs_bits-1:0];

    assign req.len = len;
    assign req.rd  = rd;
    assign req.wr  = wr;

    // accesses are aligned, so the mask never leaves the line
    assign req.mask  = line_bytes'(byte_mask) << addr[offs_bits-1:0];
    assign req.wdata = line_bits'(data_in) << {addr[offs_bits-1:0], 3'b000};

endmodule

// ==== rtl/dcache_plru.sv ====
//////////////////////////////////////////////////
// dcache tree pseudo-LRU
// 3 state bits per set, victim choice and update
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dcache_plru
    import dcache_pkg::*;
(
    input  logic                clk,
    input  logic                clr_n,
    input  logic [set_bits-1:0] set,
    input  logic                access,
    input  logic [way_bits-1:0] access_way,
    output logic [way_bits-1:0] victim_way
);

    logic [2:0] tree_q [num_sets];
    logic [2:0] tree;

    assign tree = tree_q[set];

    // bit 2 picks the half, bit 1 or bit 0 picks the way inside it
    always_comb begin
        if (tree[2]) begin
            victim_way = tree[1] ? 2'd0 : 2'd1;
        end else begin
            victim_way = tree[0] ? 2'd2 : 2'd3;
        end
    end

    // point the tree away from the way just used
    always_ff @(posedge clk or negedge clr_n) begin
        if (!clr_n) begin
            for (int s = 0; s < num_sets; s++) begin
                tree_q[s] <= 3'b000;
            end
        end else if (access) begin
            case (access_way)
                2'd0: tree_q[set] <= {2'b00, tree[0]};
                2'd1: tree_q[set] <= {2'b01, tree[0]};
                2'd2: tree_q[set] <= {1'b1, tree[1], 1'b0};
                default: tree_q[set] <= {1'b1, tree[1], 1'b1};
            endcase
        end
    end

endmodule

// ==== rtl/dcache_array.sv ====
//////////////////////////////////////////////////
// dcache storage
// tag, valid and data arrays with hit detection,
// line fill and byte-masked store merge
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dcache_array
    import dcache_pkg::*;
(
    input  logic                 clk,
    input  logic                 clr_n,
    input  dc_req_t              req,
    input  logic [line_bits-1:0] b_data_in,
    input  logic                 b_dv,
    input  logic [way_bits-1:0]  victim_way,
    output logic                 hit,
    output logic [way_bits-1:0]  hit_way,
    output logic [line_bits-1:0] hit_line,
    output bus_wr_t              wt,
    output logic                 wt_valid
);

    logic [tag_bits-1:0]  tag_q   [num_sets][num_ways];
    logic [line_bits-1:0] data_q  [num_sets][num_ways];
    logic [num_ways-1:0]  valid_q [num_sets];

    logic                 active;
    logic                 fill;
    logic                 store;
    logic [line_bits-1:0] merged;

    assign active = req.rd || req.wr;

    // tag compare across the ways of the addressed set
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (valid_q[req.set][w] && tag_q[req.set][w] == req.tag) begin
                hit     = 1'b1;
                hit_way = way_bits'(w);
            end
        end
    end

    assign hit_line = data_q[req.set][hit_way];

    // a fill only loads the line, the request then hits next cycle
    assign fill  = active && !hit && b_dv;
    assign store = req.wr && hit;

    // store bytes replace the hit line where the mask is set
    always_comb begin
        for (int i = 0; i < line_bytes; i++) begin
            merged[8*i +: 8] = req.mask[i] ? req.wdata[8*i +: 8] : hit_line[8*i +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[req.set][victim_way]  <= req.tag;
            data_q[req.set][victim_way] <= b_data_in;
        end else if (store) begin
            data_q[req.set][hit_way] <= merged;
        end
    end

    always_ff @(posedge clk or negedge clr_n) begin
        if (!clr_n) begin
            for (int s = 0; s < num_sets; s++) begin
                valid_q[s] <= '0;
            end
            wt_valid <= 1'b0;
        end else begin
            if (fill) begin
                valid_q[req.set][victim_way] <= 1'b1;
            end
            // one pulse per completed store
            wt_valid <= store;
        end
    end

    // write-through copy of the updated line
    always_ff @(posedge clk) begin
        if (store) begin
            wt.addr <= {req.tag, req.set, offs_bits'(0)};
            wt.line <= merged;
        end
    end

endmodule

// ==== rtl/dcache_load_extract.sv ====
//////////////////////////////////////////////////
// dcache load extraction
// picks the addressed bytes of the hit line and
// sign- or zero-extends them by access length
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dcache_load_extract
    import dcache_pkg::*;
(
    input  logic [line_bits-1:0] hit_line,
    input  dc_req_t              req,
    output logic [63:0]          data_out
);

    logic [line_bits-1:0] shifted;
    logic [63:0]          raw;

    // bring the addressed byte down to bit 0
    assign shifted = hit_line >> {req.offs, 3'b000};
    assign raw     = shifted[63:0];

    always_comb begin
        case (req.len)
            len_b:   data_out = {{56{raw[7]}}, raw[7:0]};
            len_h:   data_out = {{48{raw[15]}}, raw[15:0]};
            // sign comes from bit 31 of the word
            len_w:   data_out = {{32{raw[31]}}, raw[31:0]};
            len_bu:  data_out = {56'b0, raw[7:0]};
            len_hu:  data_out = {48'b0, raw[15:0]};
            len_wu:  data_out = {32'b0, raw[31:0]};
            default: data_out = raw;
        endcase
    end

endmodule

// ==== rtl/dcache_bus_port.sv ====
//////////////////////////////////////////////////
// dcache memory port
// line read requests on a miss and write-through
// of the stored line
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dcache_bus_port
    import dcache_pkg::*;
(
    input  dc_req_t              req,
    input  logic                 hit,
    input  bus_wr_t              wt,
    input  logic                 wt_valid,
    output logic [addr_bits-1:0] b_addr,
    output logic                 b_rd,
    output logic                 b_wr,
    output logic [line_bits-1:0] b_data_out
);

    logic                 miss;
    logic [addr_bits-1:0] line_addr;

    assign miss      = (req.rd || req.wr) && !hit;
    assign line_addr = {req.tag, req.set, offs_bits'(0)};

    // the write-through owns b_addr for its cycle,
    // so a read that misses right after a store waits one cycle
    assign b_rd = miss && !wt_valid;

    assign b_wr       = wt_valid;
    assign b_addr     = wt_valid ? wt.addr : line_addr;
    assign b_data_out = wt_valid ? wt.line : '0;

endmodule

// ==== rtl/dcache_top.sv ====
//////////////////////////////////////////////////
// dcache top level
// 4-set 4-way write-through L1 data cache
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
(
    input  logic                 clk,
    input  logic                 clr_n,
    input  logic [addr_bits-1:0] addr,
    input  mem_len_e             len,
    input  logic                 rd,
    input  logic                 wr,
    input  logic [63:0]          data_in,
    output logic [63:0]          data_out,
    output logic                 busy,
    output logic [addr_bits-1:0] b_addr,
    input  logic [line_bits-1:0] b_data_in,
    output logic                 b_rd,
    input  logic                 b_dv,
    output logic [line_bits-1:0] b_data_out,
    output logic                 b_wr
);

    dc_req_t              req;
    logic                 hit;
    logic [way_bits-1:0]  hit_way;
    logic [way_bits-1:0]  victim_way;
    logic [line_bits-1:0] hit_line;
    bus_wr_t              wt;
    logic                 wt_valid;

    // requester waits until the line is present
    assign busy = (rd || wr) && !hit;

    dcache_req_decode u_decode (
        .addr    (addr),
        .len     (len),
        .rd      (rd),
        .wr      (wr),
        .data_in (data_in),
        .req     (req)
    );

    dcache_array u_array (
        .clk        (clk),
        .clr_n      (clr_n),
        .req        (req),
        .b_data_in  (b_data_in),
        .b_dv       (b_dv),
        .victim_way (victim_way),
        .hit        (hit),
        .hit_way    (hit_way),
        .hit_line   (hit_line),
        .wt         (wt),
        .wt_valid   (wt_valid)
    );

    // only completed requests move the replacement tree
    dcache_plru u_plru (
        .clk        (clk),
        .clr_n      (clr_n),
        .set        (req.set),
        .access     (hit && (rd || wr)),
        .access_way (hit_way),
        .victim_way (victim_way)
    );

    dcache_load_extract u_extract (
        .hit_line (hit_line),
        .req      (req),
        .data_out (data_out)
    );

    dcache_bus_port u_bus (
        .req        (req),
        .hit        (hit),
        .wt         (wt),
        .wt_valid   (wt_valid),
        .b_addr     (b_addr),
        .b_rd       (b_rd),
        .b_wr       (b_wr),
        .b_data_out (b_data_out)
    );

endmodule

// ==== tests/dcache_properties.sv ====
//////////////////////////////////////////////////
// dcache protocol assertions
// bus pulse, request and fill rules
//////////////////////////////////////////////////

`timescale 1ns/1ps

module dcache_properties
    import dcache_pkg::*;
(
    input logic     clk,
    input logic     clr_n,
    input logic     rd,
    input logic     wr,
    input mem_len_e len,
    input logic     b_rd,
    input logic     b_wr,
    input logic     b_dv
);

    int fail_count = 0;

    a_wr_pulse: assert property (@(posedge clk) disable iff (!clr_n) b_wr |=> !b_wr)
        else begin
            fail_count++;
            $error("b_wr stayed high for more than one cycle");
        end

    a_rd_wr: assert property (@(posedge clk) disable iff (!clr_n) !(rd && wr))
        else begin
            fail_count++;
            $error("rd and wr high together");
        end

    // funct3 value 7 has no access length
    a_len: assert property (@(posedge clk) disable iff (!clr_n) (rd || wr) |-> len != 3'd7)
        else begin
            fail_count++;
            $error("illegal len on an active request");
        end

    a_dv: assert property (@(posedge clk) disable iff (!clr_n) b_dv |-> b_rd)
        else begin
            fail_count++;
            $error("b_dv strobed while b_rd was low");
        end

endmodule

// ==== tests/tb_dcache.sv ====
//////////////////////////////////////////////////
// dcache testbench
// random loads and stores against a byte model,
// line memory with random fill delay, PLRU model
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_dcache
    import dcache_pkg::*;
();

    localparam int num_random = 200;
    localparam int num_retention = 20;
    localparam int num_evict = 5;
    localparam int total_ops = num_random + num_retention + num_evict;

    logic                 clk;
    logic                 clr_n;
    logic [addr_bits-1:0] addr;
    mem_len_e             len;
    logic                 rd;
    logic                 wr;
    logic [63:0]          data_in;
    logic [63:0]          data_out;
    logic                 busy;
    logic [addr_bits-1:0] b_addr;
    logic [line_bits-1:0] b_data_in = '0;
    logic                 b_rd;
    logic                 b_dv = 1'b0;
    logic [line_bits-1:0] b_data_out;
    logic                 b_wr;

    logic [31:0] stim_state = 32'h4ccea3d5;
    logic [31:0] mem_state = 32'h4ccea3d5 ^ 32'h9e3779b9;
    logic [7:0]           ref_mem [logic [addr_bits-1:0]];
    logic [line_bits-1:0] mem_lines [logic [addr_bits-1:0]];
    int errors = 0;
    int checks = 0;
    int fills = 0;
    int wr_pulses = 0;
    int stores = 0;
    int rd_wait = 0;
    logic rd_pending = 1'b0;

    // set 0 replacement model for the retention and eviction tests
    logic [2:0]          plru_tree;
    logic [tag_bits-1:0] way_tag [num_ways];
    logic [num_ways-1:0] way_valid;

    dcache_top DUT (
        .clk(clk), .clr_n(clr_n), .addr(addr), .len(len), .rd(rd), .wr(wr),
        .data_in(data_in), .data_out(data_out), .busy(busy), .b_addr(b_addr),
        .b_data_in(b_data_in), .b_rd(b_rd), .b_dv(b_dv), .b_data_out(b_data_out), .b_wr(b_wr)
    );

    bind dcache_top dcache_properties u_props (
        .clk(clk), .clr_n(clr_n), .rd(rd), .wr(wr), .len(len),
        .b_rd(b_rd), .b_wr(b_wr), .b_dv(b_dv)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        stim_state = lcg_step(stim_state);
        return stim_state;
    endfunction

    // power-up memory content folding every address byte
    function automatic logic [7:0] fill_byte(input logic [addr_bits-1:0] a);
        logic [7:0] b;
        b = 8'h5a;
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], b[7]} ^ a[8*i +: 8];
        end
        return b;
    endfunction

    function automatic logic [7:0] ref_byte(input logic [addr_bits-1:0] a);
        return ref_mem.exists(a) ? ref_mem[a] : fill_byte(a);
    endfunction

    function automatic logic [line_bits-1:0] mem_line(input logic [addr_bits-1:0] a);
        logic [line_bits-1:0] l;
        if (mem_lines.exists(a)) begin
            return mem_lines[a];
        end
        for (int i = 0; i < line_bytes; i++) begin
            l[8*i +: 8] = fill_byte(a + i);
        end
        return l;
    endfunction

    function automatic logic [63:0] load_expect(input logic [addr_bits-1:0] a, input mem_len_e l);
        int n;
        logic [63:0] v;
        n = 1 << l[1:0];
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = ref_byte(a + i);
        end
        // signed lengths copy the top loaded bit upward
        if (!l[2]) begin
            for (int i = 8 * n; i < 64; i++) begin
                v[i] = v[8*n-1];
            end
        end
        return v;
    endfunction

    function automatic int victim_of(input logic [2:0] t);
        if (t[2]) begin
            return t[1] ? 0 : 1;
        end
        return t[0] ? 2 : 3;
    endfunction

    function automatic int model_access(input logic [tag_bits-1:0] t);
        int way;
        int miss;
        way = -1;
        miss = 0;
        for (int w = 0; w < num_ways; w++) begin
            if (way_valid[w] && way_tag[w] == t) way = w;
        end
        if (way < 0) begin
            miss = 1;
            way = victim_of(plru_tree);
            way_tag[way] = t;
            way_valid[way] = 1'b1;
        end
        plru_tree[2] = (way >= 2);
        if (way < 2) plru_tree[1] = (way == 1);
        else plru_tree[0] = (way == 3);
        return miss;
    endfunction

    task automatic check_load(input logic [63:0] got, input logic [63:0] exp,
                              input logic [addr_bits-1:0] a);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: load from %h gave %h, expected %h", $time, a, got, exp);
        end
    endtask

    task automatic check_line(input bus_wr_t got, input bus_wr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: write-through to %h, expected %h, line %s", $time,
                     got.addr, exp.addr, (got.line === exp.line) ? "matches" : "differs");
        end
    endtask

    task automatic check_addr(input logic [addr_bits-1:0] got, input logic [addr_bits-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: b_addr %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        clr_n <= 1'b0;
        repeat (3) @(posedge clk);
        clr_n <= 1'b1;
    endtask

    // one request, held until busy drops, then one idle cycle
    task automatic run_op(input logic is_wr, input logic [addr_bits-1:0] a, input mem_len_e l,
                          input logic [63:0] d, output logic missed);
        logic saw_rd;
        logic saw_dv;
        bus_wr_t got_wt;
        bus_wr_t exp_wt;
        logic [addr_bits-1:0] base;
        base = {a[addr_bits-1:offs_bits], offs_bits'(0)};
        @(posedge clk);
        addr <= a;
        len <= l;
        rd <= !is_wr;
        wr <= is_wr;
        data_in <= d;
        missed = 1'b0;
        saw_rd = 1'b0;
        saw_dv = 1'b0;
        @(negedge clk);
        while (busy) begin
            missed = 1'b1;
            if (b_rd) begin
                saw_rd = 1'b1;
                check_addr(b_addr, base);
            end
            if (b_dv) saw_dv = 1'b1;
            @(negedge clk);
        end
        if (missed && !(saw_rd && saw_dv)) begin
            errors++;
            $display("missed request to %h completed without a line read and fill", a);
        end
        if (!is_wr) begin
            check_load(data_out, load_expect(a, l), a);
        end else begin
            stores++;
            for (int i = 0; i < (1 << l[1:0]); i++) begin
                ref_mem[a + i] = d[8*i +: 8];
            end
        end
        @(posedge clk);
        rd <= 1'b0;
        wr <= 1'b0;
        if (is_wr) begin
            exp_wt.addr = base;
            for (int i = 0; i < line_bytes; i++) begin
                exp_wt.line[8*i +: 8] = ref_byte(base + i);
            end
            @(negedge clk);
            got_wt.addr = b_addr;
            got_wt.line = b_data_out;
            if (!b_wr) begin
                errors++;
                $display("no write-through pulse in the cycle after the store to %h", a);
            end else begin
                check_line(got_wt, exp_wt);
            end
        end
    endtask

    task automatic random_access(input logic [tag_bits-1:0] t, input logic [set_bits-1:0] s,
                                 output logic missed);
        logic [31:0] r;
        mem_len_e l;
        logic [offs_bits-1:0] o;
        r = next_rand();
        l = mem_len_e'(3'((r >> 8) % 7));
        o = r[22:16] & ~offs_bits'((1 << l[1:0]) - 1);
        run_op(r[28], {t, s, o}, l, {next_rand(), next_rand()}, missed);
    endtask

    task automatic random_test();
        int err0;
        int wr0;
        int st0;
        logic [31:0] r;
        logic missed;
        err0 = errors;
        wr0 = wr_pulses;
        st0 = stores;
        for (int i = 0; i < num_random; i++) begin
            r = next_rand();
            random_access(tag_bits'(32'h2b0 + (r >> 8) % 5), r[20] ? 2'd1 : 2'd2, missed);
        end
        // the pulse counter samples on the same edge as the last store check
        @(posedge clk);
        check_count(wr_pulses - wr0, stores - st0, "write-through pulses");
        $display("random access test: %0d ops, %0d errors", num_random, errors - err0);
    endtask

    task automatic retention_test();
        int err0;
        int fill0;
        int k;
        logic missed;
        err0 = errors;
        apply_reset();
        plru_tree = '0;
        way_valid = '0;
        fill0 = fills;
        for (int i = 0; i < 4; i++) begin
            random_access(tag_bits'(32'h700 + i), 2'd0, missed);
            check_count(missed, model_access(tag_bits'(32'h700 + i)), "miss on first touch");
        end
        for (int i = 0; i < num_retention - 4; i++) begin
            k = (next_rand() >> 8) % 4;
            random_access(tag_bits'(32'h700 + k), 2'd0, missed);
            check_count(missed, model_access(tag_bits'(32'h700 + k)), "miss on re-access");
        end
        check_count(fills - fill0, 4, "fills for four tags in one set");
        $display("retention test: %0d ops, %0d errors", num_retention, errors - err0);
    endtask

    task automatic evict_test();
        int err0;
        int fill0;
        logic [tag_bits-1:0] vt;
        logic missed;
        err0 = errors;
        fill0 = fills;
        vt = way_tag[victim_of(plru_tree)];
        random_access(tag_bits'(32'h7ff), 2'd0, missed);
        check_count(missed, model_access(tag_bits'(32'h7ff)), "miss on fifth tag");
        for (int i = 0; i < 4; i++) begin
            if (tag_bits'(32'h700 + i) != vt) begin
                random_access(tag_bits'(32'h700 + i), 2'd0, missed);
                check_count(missed, 0, "miss on a kept tag");
                void'(model_access(tag_bits'(32'h700 + i)));
            end
        end
        random_access(vt, 2'd0, missed);
        check_count(missed, 1, "miss on evicted tag");
        void'(model_access(vt));
        check_count(fills - fill0, 2, "fills during eviction");
        $display("eviction test: %0d ops, %0d errors", num_evict, errors - err0);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // line memory answering b_rd after 1 to 4 cycles
    always @(posedge clk) begin
        if (b_wr) mem_lines[b_addr] = b_data_out;
        if (b_dv) begin
            b_dv <= 1'b0;
        end else if (b_rd) begin
            if (!rd_pending) begin
                rd_pending = 1'b1;
                mem_state = lcg_step(mem_state);
                rd_wait = (mem_state >> 8) % 4;
            end
            if (rd_wait == 0) begin
                rd_pending = 1'b0;
                b_dv <= 1'b1;
                b_data_in <= mem_line(b_addr);
            end else begin
                rd_wait--;
            end
        end
    end

    always @(negedge clk) begin
        if (clr_n && b_wr) wr_pulses++;
        if (clr_n && b_dv) fills++;
    end

    initial begin
        repeat (total_ops * 10) @(posedge clk);
        $display("watchdog expired after %0d cycles with tests still running", total_ops * 10);
        $display("Test failed");
        $finish;
    end

    initial begin
        clr_n = 1'b0;
        addr = '0;
        len = len_b;
        rd = 1'b0;
        wr = 1'b0;
        data_in = '0;
        apply_reset();
        random_test();
        retention_test();
        evict_test();
        repeat (2) @(posedge clk);
        $display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
                 DUT.u_props.fail_count);
        if (errors == 0 && DUT.u_props.fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
rtl/dcache_pkg.sv
rtl/dcache_req_decode.sv
rtl/dcache_plru.sv
rtl/dcache_array.sv
rtl/dcache_load_extract.sv
rtl/dcache_bus_port.sv
rtl/dcache_top.sv
tests/dcache_properties.sv
tests/tb_dcache.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - rtl/dcache_pkg.sv
  - rtl/dcache_req_decode.sv
  - rtl/dcache_plru.sv
  - rtl/dcache_array.sv
  - rtl/dcache_load_extract.sv
  - rtl/dcache_bus_port.sv
  - rtl/dcache_top.sv
  - target: test
    files:
      - tests/dcache_properties.sv
      - tests/tb_dcache.sv
